/* source/flush_pkg.sv */
`default_nettype none

package flush_pkg;

    // --------------------
    // Widths
    // --------------------
    localparam int unsigned COMMIT_KIND_W = 4;   // Encoded retiring event kind
    localparam int unsigned PERF_CNT_W    = 16;  // One performance counter

    // Data cache policy
    // 1 means write-back, so fences must flush dirty lines
    localparam bit DCACHE_WRITE_BACK = 1'b1;

    // --------------------
    // Commit event kinds
    // --------------------
    // At most one of these retires per cycle
    typedef enum logic [COMMIT_KIND_W-1:0] {
        commit_none         = 4'd0,
        commit_fence        = 4'd1,   // fence
        commit_fence_i      = 4'd2,   // fence.i
        commit_sfence_vma   = 4'd3,   // sfence.vma
        commit_hfence_vvma  = 4'd4,   // hfence.vvma
        commit_hfence_gvma  = 4'd5,   // hfence.gvma
        commit_flush_csr    = 4'd6,   // CSR write with side effects
        commit_flush_commit = 4'd7,   // Flush asked for by commit
        commit_exception    = 4'd8,   // Trap taken
        commit_eret         = 4'd9,   // Return from trap
        commit_debug_pc     = 4'd10   // Jump to debug PC
    } commit_kind_e;

    // Wrapping event counter
    typedef logic [PERF_CNT_W-1:0] perf_cnt_t;

endpackage

`default_nettype wire

/* source/flush_req_if.sv */
`timescale 1ns/1ns
`default_nettype none

// Decoded commit events, one-cycle registered levels
interface flush_req_if;

    logic mispredict;   // Branch mispredict resolved
    logic fence;        // fence retired
    logic fence_i;      // fence.i retired
    logic sfence_vma;   // sfence.vma retired
    logic hfence_vvma;  // hfence.vvma retired
    logic hfence_gvma;  // hfence.gvma retired
    logic flush_pipe;   // CSR side effect or commit flush
    logic trap;         // Exception or eret
    logic debug_pc;     // Debug entry, same handling as trap
    logic virt;         // Virtualization mode with the event

    modport decoder (
        output mispredict, fence, fence_i, sfence_vma, hfence_vvma, hfence_gvma,
        output flush_pipe, trap, debug_pc, virt
    );

    modport ctrl (
        input mispredict, fence, fence_i, sfence_vma, hfence_vvma, hfence_gvma,
        input flush_pipe, trap, debug_pc, virt
    );

endinterface

`default_nettype wire

/* source/flush_cmd_if.sv */
`timescale 1ns/1ns
`default_nettype none

// Flush commands from the controller
interface flush_cmd_if;

    logic set_pc_commit;   // Take the PC from commit
    logic flush_if;        // Fetch stage
    logic flush_unissued;  // Un-issued scoreboard entries
    logic flush_id;        // Decode stage
    logic flush_ex;        // Execute stage
    logic flush_bp;        // Branch predictors
    logic flush_icache;    // Instruction cache
    logic flush_tlb;       // Normal TLB
    logic flush_tlb_vvma;  // Guest virtual TLB
    logic flush_tlb_gvma;  // Guest physical TLB
    logic flush_dcache;    // Registered, held until ack
    logic fence_active;    // Data cache flush in progress

    modport ctrl (
        output set_pc_commit, flush_if, flush_unissued, flush_id, flush_ex, flush_bp,
        output flush_icache, flush_tlb, flush_tlb_vvma, flush_tlb_gvma,
        output flush_dcache, fence_active
    );

    // Monitor only needs the flush kind and the fence state
    modport monitor (
        input flush_if, flush_id, fence_active
    );

endinterface

`default_nettype wire

/* source/commit_event_decoder.sv */
`timescale 1ns/1ns
`default_nettype none

module commit_event_decoder import flush_pkg::*; (
    input  logic         clk_i,
    input  logic         rst_ni,
    input  logic         commit_valid_i,  // Commit report valid
    input  commit_kind_e commit_kind_i,   // Retiring event kind
    input  logic         virt_mode_i,     // Current virtualization mode
    input  logic         mispredict_i,    // Independent of commit_valid_i
    flush_req_if.decoder req_o
);

    // Next-cycle strobes
    logic fence_d, fence_i_d;
    logic sfence_vma_d, hfence_vvma_d, hfence_gvma_d;
    logic flush_pipe_d, trap_d, debug_pc_d;

    // --------------------
    // Kind decode
    // --------------------
    always_comb begin : kind_decode
        fence_d       = 1'b0;
        fence_i_d     = 1'b0;
        sfence_vma_d  = 1'b0;
        hfence_vvma_d = 1'b0;
        hfence_gvma_d = 1'b0;
        flush_pipe_d  = 1'b0;
        trap_d        = 1'b0;
        debug_pc_d    = 1'b0;
        if (commit_valid_i) begin
            case (commit_kind_i)
                commit_fence:        fence_d       = 1'b1;
                commit_fence_i:      fence_i_d     = 1'b1;
                commit_sfence_vma:   sfence_vma_d  = 1'b1;
                commit_hfence_vvma:  hfence_vvma_d = 1'b1;
                commit_hfence_gvma:  hfence_gvma_d = 1'b1;
                // Same pipeline flush for both
                commit_flush_csr,
                commit_flush_commit: flush_pipe_d  = 1'b1;
                // Trap entry and return flush alike
                commit_exception,
                commit_eret:         trap_d        = 1'b1;
                commit_debug_pc:     debug_pc_d    = 1'b1;
                default:             ;                     // None or unused code
            endcase
        end
    end

    // --------------------
    // Strobe registers
    // --------------------
    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            req_o.mispredict  <= 1'b0;
            req_o.fence       <= 1'b0;
            req_o.fence_i     <= 1'b0;
            req_o.sfence_vma  <= 1'b0;
            req_o.hfence_vvma <= 1'b0;
            req_o.hfence_gvma <= 1'b0;
            req_o.flush_pipe  <= 1'b0;
            req_o.trap        <= 1'b0;
            req_o.debug_pc    <= 1'b0;
            req_o.virt        <= 1'b0;
        end else begin
            req_o.mispredict  <= mispredict_i;
            req_o.fence       <= fence_d;
            req_o.fence_i     <= fence_i_d;
            req_o.sfence_vma  <= sfence_vma_d;
            req_o.hfence_vvma <= hfence_vvma_d;
            req_o.hfence_gvma <= hfence_gvma_d;
            req_o.flush_pipe  <= flush_pipe_d;
            req_o.trap        <= trap_d;
            req_o.debug_pc    <= debug_pc_d;
            req_o.virt        <= virt_mode_i;  // Sampled with the event
        end
    end

endmodule

`default_nettype wire

/* source/flush_controller.sv */
`timescale 1ns/1ns
`default_nettype none

module flush_controller import flush_pkg::*; (
    input  logic      clk_i,
    input  logic      rst_ni,
    flush_req_if.ctrl req_i,
    input  logic      flush_dcache_ack_i,  // Whole data cache flushed
    input  logic      halt_csr_i,          // Halt from CSR, e.g. WFI
    output logic      halt_o,              // Halt to commit
    flush_cmd_if.ctrl cmd_o
);

    logic fence_active_d, fence_active_q;  // Data cache flush running
    logic flush_dcache_d, flush_dcache_q;  // Unregistered and registered flush

    // --------------------
    // Flush decisions
    // --------------------
    always_comb begin : flush_ctrl
        fence_active_d       = fence_active_q;
        flush_dcache_d       = 1'b0;
        cmd_o.set_pc_commit  = 1'b0;
        cmd_o.flush_if       = 1'b0;
        cmd_o.flush_unissued = 1'b0;
        cmd_o.flush_id       = 1'b0;
        cmd_o.flush_ex       = 1'b0;
        cmd_o.flush_bp       = 1'b0;
        cmd_o.flush_icache   = 1'b0;
        cmd_o.flush_tlb      = 1'b0;
        cmd_o.flush_tlb_vvma = 1'b0;
        cmd_o.flush_tlb_gvma = 1'b0;

        // Mispredict drops the front end only
        if (req_i.mispredict) begin
            cmd_o.flush_if       = 1'b1;
            cmd_o.flush_unissued = 1'b1;
        end

        // Every fence kind restarts from the commit PC
        if (req_i.fence || req_i.fence_i || req_i.sfence_vma || req_i.hfence_vvma
                || req_i.hfence_gvma || req_i.flush_pipe) begin
            cmd_o.set_pc_commit  = 1'b1;
            cmd_o.flush_if       = 1'b1;
            cmd_o.flush_unissued = 1'b1;
            cmd_o.flush_id       = 1'b1;
            cmd_o.flush_ex       = 1'b1;
        end

        if (req_i.fence_i) begin
            cmd_o.flush_icache = 1'b1;  // Stale instructions
        end

        // Dirty lines must reach memory before the fence completes
        if (DCACHE_WRITE_BACK && (req_i.fence || req_i.fence_i)) begin
            flush_dcache_d = 1'b1;
            fence_active_d = 1'b1;
        end

        // --------------------
        // Ack wait
        // --------------------
        if (DCACHE_WRITE_BACK) begin
            if (flush_dcache_ack_i && fence_active_q) begin
                fence_active_d = 1'b0;  // Done, flush drops next edge
            end else if (fence_active_q) begin
                flush_dcache_d = 1'b1;  // Hold request until ack
            end
        end

        // TLB selection
        if (req_i.sfence_vma) begin
            if (req_i.virt) begin
                cmd_o.flush_tlb_vvma = 1'b1;  // Guest translation
            end else begin
                cmd_o.flush_tlb      = 1'b1;
            end
        end
        if (req_i.hfence_vvma) begin
            cmd_o.flush_tlb_vvma = 1'b1;
        end
        if (req_i.hfence_gvma) begin
            cmd_o.flush_tlb_gvma = 1'b1;
        end

        // Trap, eret and debug take their own target PC
        // so commit PC is not used here
        if (req_i.trap || req_i.debug_pc) begin
            cmd_o.set_pc_commit  = 1'b0;
            cmd_o.flush_if       = 1'b1;
            cmd_o.flush_unissued = 1'b1;
            cmd_o.flush_id       = 1'b1;
            cmd_o.flush_ex       = 1'b1;
            cmd_o.flush_bp       = 1'b1;  // Stop speculative fetch across modes
        end
    end

    // --------------------
    // Halt and fence state
    // --------------------
    assign halt_o             = halt_csr_i || fence_active_q;  // Stall while cache flushes
    assign cmd_o.fence_active = fence_active_q;
    assign cmd_o.flush_dcache = flush_dcache_q;

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            fence_active_q <= 1'b0;
            flush_dcache_q <= 1'b0;
        end else begin
            fence_active_q <= fence_active_d;
            flush_dcache_q <= flush_dcache_d;  // Registered for timing toward the cache
        end
    end

endmodule

`default_nettype wire

/* source/flush_perf_monitor.sv */
`timescale 1ns/1ns
`default_nettype none

module flush_perf_monitor import flush_pkg::*; (
    input  logic         clk_i,
    input  logic         rst_ni,
    flush_cmd_if.monitor cmd_i,
    input  logic         halt_o,             // Halt from the controller
    output perf_cnt_t    cnt_mispredict_o,   // Mispredict flushes
    output perf_cnt_t    cnt_fence_stall_o   // Cycles stalled on a fence
);

    logic      mispredict_hit;  // Front-end only flush this cycle
    logic      fence_stall;     // Data cache flush in progress
    perf_cnt_t cnt_mispredict_q;
    perf_cnt_t cnt_fence_stall_q;

    // --------------------
    // Event conditions
    // --------------------
    // Full flushes also raise flush_if, so ID tells them apart
    assign mispredict_hit = cmd_i.flush_if && !cmd_i.flush_id;

    // A CSR halt alone is not a fence stall
    assign fence_stall    = cmd_i.fence_active;

    // --------------------
    // Counters
    // --------------------
    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            cnt_mispredict_q  <= '0;
            cnt_fence_stall_q <= '0;
        end else begin
            if (mispredict_hit) begin
                cnt_mispredict_q <= cnt_mispredict_q + perf_cnt_t'(1);  // Wraps
            end
            if (fence_stall) begin
                cnt_fence_stall_q <= cnt_fence_stall_q + perf_cnt_t'(1);
            end
        end
    end

    assign cnt_mispredict_o  = cnt_mispredict_q;
    assign cnt_fence_stall_o = cnt_fence_stall_q;

endmodule

`default_nettype wire

/* source/flush_unit_top.sv */
`timescale 1ns/1ns
`default_nettype none

module flush_unit_top import flush_pkg::*; (
    input  logic         clk_i,
    input  logic         rst_ni,
    // Commit side
    input  logic         commit_valid_i,
    input  commit_kind_e commit_kind_i,
    input  logic         virt_mode_i,
    input  logic         mispredict_i,
    input  logic         halt_csr_i,
    input  logic         flush_dcache_ack_i,
    // Flush commands
    output logic         set_pc_commit_o,
    output logic         flush_if_o,
    output logic         flush_unissued_o,
    output logic         flush_id_o,
    output logic         flush_ex_o,
    output logic         flush_bp_o,
    output logic         flush_icache_o,
    output logic         flush_dcache_o,
    output logic         flush_tlb_o,
    output logic         flush_tlb_vvma_o,
    output logic         flush_tlb_gvma_o,
    output logic         halt_o,
    // Performance counters
    output perf_cnt_t    cnt_mispredict_o,
    output perf_cnt_t    cnt_fence_stall_o
);

    flush_req_if req ();  // Decoder to controller
    flush_cmd_if cmd ();  // Controller to monitor and ports

    commit_event_decoder u_decoder (
        .clk_i          (clk_i),
        .rst_ni         (rst_ni),
        .commit_valid_i (commit_valid_i),
        .commit_kind_i  (commit_kind_i),
        .virt_mode_i    (virt_mode_i),
        .mispredict_i   (mispredict_i),
        .req_o          (req.decoder)
    );

    flush_controller u_ctrl (
        .clk_i              (clk_i),
        .rst_ni             (rst_ni),
        .req_i              (req.ctrl),
        .flush_dcache_ack_i (flush_dcache_ack_i),
        .halt_csr_i         (halt_csr_i),
        .halt_o             (halt_o),
        .cmd_o              (cmd.ctrl)
    );

    flush_perf_monitor u_monitor (
        .clk_i             (clk_i),
        .rst_ni            (rst_ni),
        .cmd_i             (cmd.monitor),
        .halt_o            (halt_o),
        .cnt_mispredict_o  (cnt_mispredict_o),
        .cnt_fence_stall_o (cnt_fence_stall_o)
    );

    // Command outputs
    assign set_pc_commit_o  = cmd.set_pc_commit;
    assign flush_if_o       = cmd.flush_if;
    assign flush_unissued_o = cmd.flush_unissued;
    assign flush_id_o       = cmd.flush_id;
    assign flush_ex_o       = cmd.flush_ex;
    assign flush_bp_o       = cmd.flush_bp;
    assign flush_icache_o   = cmd.flush_icache;
    assign flush_dcache_o   = cmd.flush_dcache;
    assign flush_tlb_o      = cmd.flush_tlb;
    assign flush_tlb_vvma_o = cmd.flush_tlb_vvma;
    assign flush_tlb_gvma_o = cmd.flush_tlb_gvma;

endmodule

`default_nettype wire

/* verif/flush_unit_tb.sv */
`timescale 1ns/1ns
`default_nettype none

module flush_unit_tb import flush_pkg::*; ();

    localparam int    CLK_PERIOD = 4;
    localparam int    MAX_LINES  = 64;
    localparam int    MIN_LINES  = 40;   // Shorter trace cannot cover every behavior
    localparam int    NUM_FIELDS = 20;   // 6 inputs, 12 flags, 2 counters
    localparam int    MARGIN     = 10;   // Extra watchdog cycles
    localparam string TRACE_PATH = "verif/flush_trace.txt";

    logic         clk_i = 1'b0;
    logic         rst_ni;
    logic         commit_valid_i, virt_mode_i, mispredict_i;
    logic         halt_csr_i, flush_dcache_ack_i;
    commit_kind_e commit_kind_i;
    logic         set_pc_commit_o, flush_if_o, flush_unissued_o, flush_id_o, flush_ex_o;
    logic         flush_bp_o, flush_icache_o, flush_dcache_o;
    logic         flush_tlb_o, flush_tlb_vvma_o, flush_tlb_gvma_o, halt_o;
    perf_cnt_t    cnt_mispredict_o, cnt_fence_stall_o;

    logic [15:0] trace_mem [MAX_LINES][NUM_FIELDS];  // One row per cycle
    int          trace_lines  = 0;
    bit          trace_loaded = 1'b0;
    int          cur_line     = 0;                   // Row under check

    flush_unit_top uut (.*);

    initial begin : clock_gen
        forever #(CLK_PERIOD / 2) clk_i = ~clk_i;
    end

    // --------------------
    // Trace loading
    // --------------------
    task automatic load_trace();
        int          fd;
        int          n_read;
        string       line_str;
        logic [15:0] f [NUM_FIELDS];
        fd = $fopen(TRACE_PATH, "r");
        if (fd == 0) begin
            $display("Error: cannot open trace file %s", TRACE_PATH);
            $display("TESTBENCH FAILED");
            $fatal(1);
        end
        while (!$feof(fd)) begin
            line_str = "";
            if ($fgets(line_str, fd) == 0) break;
            if (line_str.len() < 2 || line_str.substr(0, 1) == "//") continue;  // Blank or note
            n_read = $sscanf(line_str, "%h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h",
                f[0], f[1], f[2], f[3], f[4], f[5], f[6], f[7], f[8], f[9],
                f[10], f[11], f[12], f[13], f[14], f[15], f[16], f[17], f[18], f[19]);
            if (n_read != NUM_FIELDS || trace_lines == MAX_LINES) begin
                $display("Error: trace row %0d is malformed or beyond the table size", trace_lines);
                $display("TESTBENCH FAILED");
                $fatal(1);
            end
            for (int i = 0; i < NUM_FIELDS; i++) trace_mem[trace_lines][i] = f[i];
            trace_lines++;
        end
        $fclose(fd);
        if (trace_lines < MIN_LINES) begin
            $display("Error: trace file is too short, only %0d rows", trace_lines);
            $display("TESTBENCH FAILED");
            $fatal(1);
        end
    endtask

    // --------------------
    // Drive and compare
    // --------------------
    task automatic check_value(input string name, input logic [15:0] actual,
                               input logic [15:0] expected);
        if (actual !== expected) begin
            $display("Fail at %0t ns: %s is %h, expected %h (trace row %0d)",
                     $time, name, actual, expected, cur_line);
            $display("TESTBENCH FAILED");
            $fatal(1);
        end
    endtask

    task automatic apply_inputs(input int k);
        commit_valid_i     = trace_mem[k][0][0];
        commit_kind_i      = commit_kind_e'(trace_mem[k][1][3:0]);
        virt_mode_i        = trace_mem[k][2][0];
        mispredict_i       = trace_mem[k][3][0];
        halt_csr_i         = trace_mem[k][4][0];
        flush_dcache_ack_i = trace_mem[k][5][0];   // Cache answer played from trace
    endtask

    task automatic check_outputs(input int k);
        check_value("set_pc_commit_o",   16'(set_pc_commit_o),  trace_mem[k][6]);
        check_value("flush_if_o",        16'(flush_if_o),       trace_mem[k][7]);
        check_value("flush_unissued_o",  16'(flush_unissued_o), trace_mem[k][8]);
        check_value("flush_id_o",        16'(flush_id_o),       trace_mem[k][9]);
        check_value("flush_ex_o",        16'(flush_ex_o),       trace_mem[k][10]);
        check_value("flush_bp_o",        16'(flush_bp_o),       trace_mem[k][11]);
        check_value("flush_icache_o",    16'(flush_icache_o),   trace_mem[k][12]);
        check_value("flush_dcache_o",    16'(flush_dcache_o),   trace_mem[k][13]);
        check_value("flush_tlb_o",       16'(flush_tlb_o),      trace_mem[k][14]);
        check_value("flush_tlb_vvma_o",  16'(flush_tlb_vvma_o), trace_mem[k][15]);
        check_value("flush_tlb_gvma_o",  16'(flush_tlb_gvma_o), trace_mem[k][16]);
        check_value("halt_o",            16'(halt_o),           trace_mem[k][17]);
        check_value("cnt_mispredict_o",  cnt_mispredict_o,      trace_mem[k][18]);
        check_value("cnt_fence_stall_o", cnt_fence_stall_o,     trace_mem[k][19]);
    endtask

    // --------------------
    // Main sequence
    // --------------------
    initial begin : main_seq
        rst_ni             = 1'b0;
        commit_valid_i     = 1'b0;
        commit_kind_i      = commit_none;
        virt_mode_i        = 1'b0;
        mispredict_i       = 1'b0;
        halt_csr_i         = 1'b0;
        flush_dcache_ack_i = 1'b0;
        load_trace();
        trace_loaded = 1'b1;
        repeat (2) @(negedge clk_i);   // Two reset cycles
        rst_ni = 1'b1;
        for (int k = 0; k < trace_lines; k++) begin
            cur_line = k;
            apply_inputs(k);           // On the falling edge
            @(posedge clk_i);
            #1;                        // Just before the next falling edge
            check_outputs(k);
            @(negedge clk_i);
        end
        $display("TESTBENCH PASSED");
        $finish;
    end

    initial begin : watchdog
        wait (trace_loaded);
        #((trace_lines + 2 + MARGIN) * CLK_PERIOD);
        $display("Error: watchdog expired before the trace was done");
        $display("TESTBENCH FAILED");
        $fatal(1);
    end

endmodule

`default_nettype wire

/* verif/flush_trace.txt */
// valid kind virt mispredict halt_csr ack | set_pc if unissued id ex bp icache dcache
// tlb tlb_vvma tlb_gvma halt | cnt_mispredict cnt_fence_stall, all hex, one row per cycle
0 0 0 0 0 0  0 0 0 0 0 0 0 0 0 0 0 0  0000 0000
0 0 0 0 0 0  0 0 0 0 0 0 0 0 0 0 0 0  0000 0000
0 0 0 1 0 0  0 1 1 0 0 0 0 0 0 0 0 0  0000 0000
0 0 0 0 0 0  0 0 0 0 0 0 0 0 0 0 0 0  0001 0000
1 3 0 0 0 0  1 1 1 1 1 0 0 0 1 0 0 0  0001 0000
1 3 1 0 0 0  1 1 1 1 1 0 0 0 0 1 0 0  0001 0000
1 4 0 0 0 0  1 1 1 1 1 0 0 0 0 1 0 0  0001 0000
1 5 0 0 0 0  1 1 1 1 1 0 0 0 0 0 1 0  0001 0000
1 6 0 0 0 0  1 1 1 1 1 0 0 0 0 0 0 0  0001 0000
1 7 0 0 0 0  1 1 1 1 1 0 0 0 0 0 0 0  0001 0000
1 8 0 0 0 0  0 1 1 1 1 1 0 0 0 0 0 0  0001 0000
1 9 0 0 0 0  0 1 1 1 1 1 0 0 0 0 0 0  0001 0000
1 a 0 0 0 0  0 1 1 1 1 1 0 0 0 0 0 0  0001 0000
1 8 0 1 0 0  0 1 1 1 1 1 0 0 0 0 0 0  0001 0000
0 0 0 0 0 0  0 0 0 0 0 0 0 0 0 0 0 0  0001 0000
1 6 0 1 0 0  1 1 1 1 1 0 0 0 0 0 0 0  0001 0000
0 0 0 1 0 0  0 1 1 0 0 0 0 0 0 0 0 0  0001 0000
0 0 0 1 0 0  0 1 1 0 0 0 0 0 0 0 0 0  0002 0000
0 0 0 0 0 0  0 0 0 0 0 0 0 0 0 0 0 0  0003 0000
0 0 0 0 1 0  0 0 0 0 0 0 0 0 0 0 0 1  0003 0000
0 0 0 0 1 0  0 0 0 0 0 0 0 0 0 0 0 1  0003 0000
0 0 0 0 0 0  0 0 0 0 0 0 0 0 0 0 0 0  0003 0000
1 1 0 0 0 0  1 1 1 1 1 0 0 0 0 0 0 0  0003 0000
0 0 0 0 0 0  0 0 0 0 0 0 0 1 0 0 0 1  0003 0000
0 0 0 0 0 0  0 0 0 0 0 0 0 1 0 0 0 1  0003 0001
0 0 0 0 0 0  0 0 0 0 0 0 0 1 0 0 0 1  0003 0002
0 0 0 0 0 1  0 0 0 0 0 0 0 0 0 0 0 0  0003 0003
0 0 0 0 0 0  0 0 0 0 0 0 0 0 0 0 0 0  0003 0003
1 2 0 0 0 0  1 1 1 1 1 0 1 0 0 0 0 0  0003 0003
0 0 0 0 0 1  0 0 0 0 0 0 0 1 0 0 0 1  0003 0003
0 0 0 0 0 1  0 0 0 0 0 0 0 0 0 0 0 0  0003 0004
0 0 0 0 0 0  0 0 0 0 0 0 0 0 0 0 0 0  0003 0004
1 1 0 0 0 0  1 1 1 1 1 0 0 0 0 0 0 0  0003 0004
0 0 0 1 0 0  0 1 1 0 0 0 0 1 0 0 0 1  0003 0004
0 0 0 0 1 0  0 0 0 0 0 0 0 1 0 0 0 1  0004 0005
0 0 0 0 1 1  0 0 0 0 0 0 0 0 0 0 0 1  0004 0006
0 0 0 0 0 0  0 0 0 0 0 0 0 0 0 0 0 0  0004 0006
0 1 0 0 0 0  0 0 0 0 0 0 0 0 0 0 0 0  0004 0006
1 0 0 0 0 0  0 0 0 0 0 0 0 0 0 0 0 0  0004 0006
0 0 0 1 0 0  0 1 1 0 0 0 0 0 0 0 0 0  0004 0006
0 0 0 0 0 0  0 0 0 0 0 0 0 0 0 0 0 0  0005 0006
0 0 0 0 0 0  0 0 0 0 0 0 0 0 0 0 0 0  0005 0006

/* vlog.f */
source/flush_pkg.sv
source/flush_req_if.sv
source/flush_cmd_if.sv
source/commit_event_decoder.sv
source/flush_controller.sv
source/flush_perf_monitor.sv
source/flush_unit_top.sv
verif/flush_unit_tb.sv

/* run_verilator.sh */
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timescale 1ns/1ns --top-module flush_unit_tb -f vlog.f -o flush_unit_sim

if ! sim_out=$(./obj_dir/flush_unit_sim 2>&1); then
    echo "$sim_out"
    echo "Simulation exited with an error"
    exit 1
fi
echo "$sim_out"

echo "$sim_out" | grep -q "TESTBENCH PASSED"
